// ==== testbench/board_stimulus.txt ====
# All fields hex. S/M frame: cmd payload bytes exp_turbo exp_reset 0
# K key: payload exp_code resend resend_payload 0 0; A audio: level exp_ones windows 0 0 0
# V video: bgr syncs(hs,vs) exp_r exp_g exp_b exp_syncs
S 1E 00000004 5 1 0 0
M 1E 00000000 4 1 0 0
M 33 00000001 5 1 0 0
M 1E 00000001 6 1 0 0
S 1E 00000005 5 1 1 0
S 1E 00000000 5 0 0 0
S 1E 00000004 5 1 0 0
K 0000021C 21C 1 00000375 0 0
K 00000375 375 0 0 0 0
K 000001F0 1F0 0 0 0 0
V 5 2 0 0 0 2
V 7 3 3F 3F 3F 3
V 2 1 0 0 0 1
V 2 3 0 3F 0 3
V 1 3 3F 0 0 3
S 1E 0000000C 5 1 0 0
V 7 2 0 0 0 2
V 7 3 3F 3F 3F 3
V 7 1 0 0 0 1
V 7 3 1F 1F 1F 3
V 2 3 0 1F 0 3
V 5 1 0 0 0 1
V 5 3 3F 0 3F 3
V 3 1 0 0 0 1
V 3 3 1F 1F 0 3
V 4 1 0 0 0 1
V 4 1 0 0 0 1
V 4 3 0 0 3F 3
A 00 0 2 0 0 0
A 80 80 2 0 0 0
A FF FF 2 0 0 0
A 37 37 1 0 0 0
A 01 1 2 0 0 0

// ==== list.f ====
hw/mist_pkg.sv
hw/spi_config_rx.sv
hw/reset_sequencer.sv
hw/video_line_timer.sv
hw/colour_channel.sv
hw/vga_output_stage.sv
hw/sigma_delta_dac.sv
hw/mist_board_top.sv
testbench/tb_mist_board_top.sv

// ==== Bender.yml ====
package:
  name: mist_board

sources:
  - hw/mist_pkg.sv
  - hw/spi_config_rx.sv
  - hw/reset_sequencer.sv
  - hw/video_line_timer.sv
  - hw/colour_channel.sv
  - hw/vga_output_stage.sv
  - hw/sigma_delta_dac.sv
  - hw/mist_board_top.sv
  - target: test
    files:
      - testbench/tb_mist_board_top.sv

// ==== testbench/tb_mist_board_top.sv ====
`timescale 1ns/10ps

module tb_mist_board_top;

	localparam int RESET_CYCLES = 16;
	localparam int SCK_HALF = 4; // clk_sys cycles per spi_sck half period.
	localparam int CYCLES_PER_RECORD = 4000;
	localparam int MAX_RECORDS = 64;
	localparam int WINDOW = 256;

	logic clk_sys, rst, button_reset;
	logic spi_sck, spi_di, spi_ss, key_ack;
	logic core_r, core_g, core_b, core_hs, core_vs;
	logic [mist_pkg::DAC_BITS-1:0] core_audio;
	logic core_reset, turbo, key_req;
	logic [10:0] key_code;
	logic [mist_pkg::COLOUR_BITS-1:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_l, audio_r;

	byte rec_kind [MAX_RECORDS];
	logic [31:0] rec_field [MAX_RECORDS][6];
	int num_records = 0;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	integer seed = 32'ha307;
	logic expect_reset_req = 1'b0;
	logic [19:0] video_exp_q [$]; // {r, g, b, hs, vs} due at the VGA pins.

	mist_board_top u_mist_board_top (
		.clk_sys(clk_sys), .rst(rst), .button_reset(button_reset),
		.spi_sck(spi_sck), .spi_di(spi_di), .spi_ss(spi_ss), .key_ack(key_ack),
		.core_r(core_r), .core_g(core_g), .core_b(core_b),
		.core_hs(core_hs), .core_vs(core_vs), .core_audio(core_audio),
		.core_reset(core_reset), .turbo(turbo), .key_req(key_req), .key_code(key_code),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Cycles since reset, so audio windows line up with the accumulator reset.
	always @(posedge clk_sys) begin
		if (rst)
			cycle_count <= 0;
		else
			cycle_count <= cycle_count + 1;
	end

	task automatic check_level(input logic [mist_pkg::COLOUR_BITS-1:0] got,
			input logic [mist_pkg::COLOUR_BITS-1:0] want, input string what);
		if (got !== want) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want) begin
			$display("error at %0t: %s is %b, expected %b", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_key(input logic [10:0] got, input logic [10:0] want,
			input string what);
		if (got !== want) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_ones(input logic [mist_pkg::DAC_BITS:0] got,
			input logic [mist_pkg::DAC_BITS:0] want, input string what);
		if (got !== want) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int got;
		int count;
		int j;
		byte kind;
		logic [8*160-1:0] rest;
		logic [31:0] f [6];
		count = 0;
		fd = $fopen("testbench/board_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file testbench/board_stimulus.txt");
			other_errors++;
		end else begin
			while (!$feof(fd) && count < MAX_RECORDS) begin
				got = $fscanf(fd, " %c", kind);
				if (got == 1 && kind == "#") begin
					got = $fgets(rest, fd); // Comment line.
				end else if (got == 1) begin
					got = $fscanf(fd, " %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5]);
					if (got == 6) begin
						rec_kind[count] = kind;
						for (j = 0; j < 6; j++)
							rec_field[count][j] = f[j];
						count++;
					end else begin
						$display("stimulus record %0d has too few fields", count);
						other_errors++;
					end
				end
			end
			$fclose(fd);
		end
		num_records = count;
	endtask

	// Sends one mode 0 frame MSB first. Bytes past the payload go out as zero.
	task automatic send_frame(input logic [7:0] cmd, input logic [31:0] payload,
			input int nbytes);
		logic [47:0] bits;
		bits = {cmd, payload, 8'h00};
		@(posedge clk_sys);
		spi_ss <= 1'b0;
		repeat (SCK_HALF) @(posedge clk_sys);
		for (int i = 0; i < nbytes * 8; i++) begin
			spi_di <= bits[47 - i];
			repeat (SCK_HALF) @(posedge clk_sys);
			spi_sck <= 1'b1;
			repeat (SCK_HALF) @(posedge clk_sys);
			spi_sck <= 1'b0;
		end
		repeat (SCK_HALF) @(posedge clk_sys);
		spi_ss <= 1'b1;
	endtask

	task automatic status_frame_test(input logic [7:0] cmd, input logic [31:0] payload,
			input int nbytes, input logic exp_turbo, input logic exp_reset);
		send_frame(cmd, payload, nbytes);
		repeat (3) @(posedge clk_sys); // Status lands three cycles after spi_ss rises.
		@(negedge clk_sys);
		check_bit(turbo, exp_turbo, "turbo after frame");
		check_bit(key_req, 1'b0, "key_req after a frame that is no key frame");
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (exp_reset) begin
			check_bit(core_reset, 1'b1, "core_reset while reset is requested");
		end else if (expect_reset_req) begin
			// The request dropped one cycle ago, so the hold has just started.
			repeat (int'(mist_pkg::RESET_HOLD) - 2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_bit(core_reset, 1'b1, "core_reset one cycle before release");
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_bit(core_reset, 1'b0, "core_reset after the hold time");
		end else begin
			check_bit(core_reset, 1'b0, "core_reset without a reset request");
		end
		expect_reset_req = exp_reset;
	endtask

	task automatic key_handshake_test(input logic [31:0] payload,
			input logic [10:0] exp_code, input logic resend,
			input logic [31:0] resend_payload);
		int delay;
		int waited;
		send_frame(mist_pkg::CMD_KEY, payload, 5);
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(key_req, 1'b1, "key_req after key frame");
		check_key(key_code, exp_code, "key_code with key_req");
		delay = ($random(seed) & 7) + 1;
		repeat (delay) @(posedge clk_sys);
		key_ack <= 1'b1;
		waited = 0;
		while (waited == 0 || (key_req && waited < 16)) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			waited++;
		end
		if (key_req) begin
			$display("key handshake never completed, key_req stayed high after key_ack rose");
			other_errors++;
		end else if (waited != 1) begin
			$display("error at %0t: key_req fell %0d cycles after key_ack, expected 1",
				$time, waited);
			value_errors++;
		end
		if (resend) begin
			send_frame(mist_pkg::CMD_KEY, resend_payload, 5); // Must be dropped.
			repeat (3) @(posedge clk_sys);
			@(negedge clk_sys);
			check_bit(key_req, 1'b0, "key_req for a key frame sent during key_ack");
			check_key(key_code, exp_code, "key_code after a dropped key frame");
		end
		@(posedge clk_sys);
		key_ack <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(key_req, 1'b0, "key_req after key_ack fell");
		check_key(key_code, exp_code, "key_code held after the handshake");
	endtask

	task automatic compare_video();
		logic [19:0] want;
		want = video_exp_q.pop_front();
		check_level(vga_r, want[19:14], "vga_r");
		check_level(vga_g, want[13:8], "vga_g");
		check_level(vga_b, want[7:2], "vga_b");
		check_bit(vga_hs, want[1], "vga_hs");
		check_bit(vga_vs, want[0], "vga_vs");
	endtask

	// One vector per cycle; the result is due VIDEO_LATENCY vectors later.
	task automatic video_vector(input logic [2:0] bgr, input logic [1:0] syncs,
			input logic [5:0] er, input logic [5:0] eg, input logic [5:0] eb,
			input logic [1:0] esyncs);
		@(posedge clk_sys);
		core_r <= bgr[0];
		core_g <= bgr[1];
		core_b <= bgr[2];
		core_hs <= syncs[1];
		core_vs <= syncs[0];
		video_exp_q.push_back({er, eg, eb, esyncs});
		@(negedge clk_sys);
		if (video_exp_q.size() > mist_pkg::VIDEO_LATENCY)
			compare_video();
	endtask

	task automatic drain_video();
		while (video_exp_q.size() > 0) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			compare_video();
		end
	endtask

	task automatic audio_window_test(input logic [7:0] level, input logic [8:0] exp_ones,
			input int windows);
		logic [8:0] ones;
		@(posedge clk_sys);
		core_audio <= level;
		@(posedge clk_sys); // First accumulator step with the new level.
		@(negedge clk_sys);
		while (cycle_count % WINDOW != 0)
			@(negedge clk_sys);
		repeat (windows) begin
			ones = '0;
			repeat (WINDOW) begin
				ones = ones + {8'd0, audio_l};
				if (audio_r !== audio_l) begin
					$display("error at %0t: audio_r differs from audio_l", $time);
					value_errors++;
				end
				@(negedge clk_sys);
			end
			check_ones(ones, exp_ones, "ones in a 256-cycle window of audio_l");
		end
	endtask

	initial begin : watchdog
		wait (num_records > 0);
		repeat (num_records * CYCLES_PER_RECORD + RESET_CYCLES + int'(mist_pkg::RESET_HOLD))
			@(posedge clk_sys);
		$display("timeout, the stimulus did not finish in the expected number of cycles");
		$display("Something failed");
		$finish;
	end

	initial begin : main
		int i;
		rst <= 1'b1;
		button_reset <= 1'b0;
		spi_sck <= 1'b0;
		spi_di <= 1'b0;
		spi_ss <= 1'b1;
		key_ack <= 1'b0;
		core_r <= 1'b0;
		core_g <= 1'b0;
		core_b <= 1'b0;
		core_hs <= 1'b1;
		core_vs <= 1'b1;
		core_audio <= '0;
		load_stimulus();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst <= 1'b0;
		repeat (int'(mist_pkg::RESET_HOLD) - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(core_reset, 1'b1, "core_reset one cycle before release");
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit(core_reset, 1'b0, "core_reset after the hold time");
		if (num_records == 0) begin
			$display("the stimulus file holds no records");
			other_errors++;
		end
		for (i = 0; i < num_records; i++) begin
			if (rec_kind[i] != "V")
				drain_video();
			case (rec_kind[i])
				"S", "M": status_frame_test(rec_field[i][0][7:0], rec_field[i][1],
					rec_field[i][2], rec_field[i][3][0], rec_field[i][4][0]);
				"K": key_handshake_test(rec_field[i][0], rec_field[i][1][10:0],
					rec_field[i][2][0], rec_field[i][3]);
				"V": video_vector(rec_field[i][0][2:0], rec_field[i][1][1:0],
					rec_field[i][2][5:0], rec_field[i][3][5:0], rec_field[i][4][5:0],
					rec_field[i][5][1:0]);
				"A": audio_window_test(rec_field[i][0][7:0], rec_field[i][1][8:0],
					rec_field[i][2]);
				default: begin
					$display("stimulus record %0d has an unknown kind %c", i, rec_kind[i]);
					other_errors++;
				end
			endcase
		end
		drain_video();
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== hw/mist_board_top.sv ====
`timescale 1ns/10ps

module mist_board_top (
	input logic clk_sys,
	input logic rst,
	input logic button_reset,
	input logic spi_sck,
	input logic spi_di,
	input logic spi_ss,
	input logic key_ack,
	input logic core_r,
	input logic core_g,
	input logic core_b,
	input logic core_hs,
	input logic core_vs,
	input logic [mist_pkg::DAC_BITS-1:0] core_audio,
	output logic core_reset,
	output logic turbo,
	output logic key_req,
	output logic [10:0] key_code,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_r,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_g,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic audio_l,
	output logic audio_r
);

	logic scanlines_on;
	logic status_reset;
	logic [mist_pkg::NUM_CHANNELS-1:0] pix;
	logic hs_d;
	logic vs_d;
	logic dim;
	logic [mist_pkg::COLOUR_BITS-1:0] level [mist_pkg::NUM_CHANNELS];

	spi_config_rx u_spi_config_rx (
		.clk_sys(clk_sys),
		.rst(rst),
		.spi_sck(spi_sck),
		.spi_di(spi_di),
		.spi_ss(spi_ss),
		.key_ack(key_ack),
		.key_req(key_req),
		.key_code(key_code),
		.turbo(turbo),
		.scanlines_on(scanlines_on),
		.status_reset(status_reset)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys(clk_sys),
		.rst(rst),
		.button_reset(button_reset),
		.status_reset(status_reset),
		.core_reset(core_reset)
	);

	video_line_timer u_video_line_timer (
		.clk_sys(clk_sys),
		.rst(rst),
		.core_r(core_r),
		.core_g(core_g),
		.core_b(core_b),
		.core_hs(core_hs),
		.core_vs(core_vs),
		.scanlines_on(scanlines_on),
		.pix(pix),
		.hs_d(hs_d),
		.vs_d(vs_d),
		.dim(dim)
	);

	// Channel 0 is red, 1 green, 2 blue.
	for (genvar i = 0; i < mist_pkg::NUM_CHANNELS; i++) begin : g_channel
		colour_channel u_colour_channel (
			.clk_sys(clk_sys),
			.rst(rst),
			.pix_bit(pix[i]),
			.dim(dim),
			.level(level[i])
		);
	end

	vga_output_stage u_vga_output_stage (
		.clk_sys(clk_sys),
		.rst(rst),
		.hs_d(hs_d),
		.vs_d(vs_d),
		.level_r(level[0]),
		.level_g(level[1]),
		.level_b(level[2]),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys(clk_sys),
		.rst(rst),
		.sample(core_audio),
		.dac_out(audio_l)
	);

	assign audio_r = audio_l; // The core is mono, so both pins carry the same stream.

endmodule

// ==== hw/sigma_delta_dac.sv ====
`timescale 1ns/10ps

module sigma_delta_dac (
	input logic clk_sys,
	input logic rst,
	input logic [mist_pkg::DAC_BITS-1:0] sample,
	output logic dac_out
);

	logic [mist_pkg::DAC_BITS:0] acc;
	logic [mist_pkg::DAC_BITS:0] acc_next;

	// The low bits carry the error, the top bit is the overflow.
	assign acc_next = {1'b0, acc[mist_pkg::DAC_BITS-1:0]} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (rst)
			acc <= '0;
		else
			acc <= acc_next;
	end

	// After 256 steps the error returns to where it started, so the carries
	// add up to the sample value exactly.
	assign dac_out = acc[mist_pkg::DAC_BITS];

endmodule

// ==== hw/vga_output_stage.sv ====
`timescale 1ns/10ps

module vga_output_stage (
	input logic clk_sys,
	input logic rst,
	input logic hs_d,
	input logic vs_d,
	input logic [mist_pkg::COLOUR_BITS-1:0] level_r,
	input logic [mist_pkg::COLOUR_BITS-1:0] level_g,
	input logic [mist_pkg::COLOUR_BITS-1:0] level_b,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_r,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_g,
	output logic [mist_pkg::COLOUR_BITS-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	logic hs_q;
	logic vs_q;
	logic visible;

	// Syncs here line up with the channel levels.
	assign visible = hs_q & vs_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			hs_q <= hs_d;
			vs_q <= vs_d;
			vga_hs <= hs_q;
			vga_vs <= vs_q;
			vga_r <= visible ? level_r : '0; // Blank during either sync.
			vga_g <= visible ? level_g : '0;
			vga_b <= visible ? level_b : '0;
		end
	end

endmodule

// ==== hw/colour_channel.sv ====
`timescale 1ns/10ps

module colour_channel (
	input logic clk_sys,
	input logic rst,
	input logic pix_bit,
	input logic dim,
	output logic [mist_pkg::COLOUR_BITS-1:0] level
);

	logic [mist_pkg::COLOUR_BITS-1:0] lit_level;

	// A dimmed line shows lit pixels at roughly half brightness.
	assign lit_level = dim ? mist_pkg::LIT_DIM : mist_pkg::LIT_FULL;

	always_ff @(posedge clk_sys) begin
		if (rst)
			level <= '0;
		else if (pix_bit)
			level <= lit_level;
		else
			level <= '0; // Unlit pixels are black whatever the line.
	end

endmodule

// ==== hw/video_line_timer.sv ====
`timescale 1ns/10ps

module video_line_timer (
	input logic clk_sys,
	input logic rst,
	input logic core_r,
	input logic core_g,
	input logic core_b,
	input logic core_hs,
	input logic core_vs,
	input logic scanlines_on,
	output logic [mist_pkg::NUM_CHANNELS-1:0] pix,
	output logic hs_d,
	output logic vs_d,
	output logic dim
);

	logic line_odd;
	logic hs_fall;

	// Syncs are active low, so a line starts where hsync falls.
	assign hs_fall = hs_d & ~core_hs;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pix <= '0;
			hs_d <= 1'b1;
			vs_d <= 1'b1;
		end else begin
			pix <= {core_b, core_g, core_r}; // Bit 0 red, bit 1 green, bit 2 blue.
			hs_d <= core_hs;
			vs_d <= core_vs;
		end
	end

	// Line parity restarts at zero during vertical sync.
	always_ff @(posedge clk_sys) begin
		if (rst)
			line_odd <= 1'b0;
		else if (!core_vs)
			line_odd <= 1'b0;
		else if (hs_fall)
			line_odd <= ~line_odd;
	end

	// Parity moves on the same edge as the pixel that starts the line.
	assign dim = line_odd & scanlines_on;

endmodule

// ==== hw/reset_sequencer.sv ====
`timescale 1ns/10ps

module reset_sequencer (
	input logic clk_sys,
	input logic rst,
	input logic button_reset,
	input logic status_reset,
	output logic core_reset
);

	logic [7:0] hold_cnt;
	logic any_cause;

	assign any_cause = rst | button_reset | status_reset;

	// Counts up from the moment the last cause drops.
	always_ff @(posedge clk_sys) begin
		if (any_cause)
			hold_cnt <= 8'd0;
		else if (hold_cnt != mist_pkg::RESET_HOLD)
			hold_cnt <= hold_cnt + 8'd1;
	end

	// Released once the counter has saturated.
	assign core_reset = (hold_cnt != mist_pkg::RESET_HOLD);

endmodule

// ==== hw/spi_config_rx.sv ====
`timescale 1ns/10ps

module spi_config_rx (
	input logic clk_sys,
	input logic rst,
	input logic spi_sck,
	input logic spi_di,
	input logic spi_ss,
	input logic key_ack,
	output logic key_req,
	output logic [10:0] key_code,
	output logic turbo,
	output logic scanlines_on,
	output logic status_reset
);

	logic sck_meta, sck_s, sck_prev;
	logic di_meta, di_s;
	logic ss_meta, ss_s, ss_prev;
	logic sck_rise;
	logic ss_rise;
	logic [2:0] bit_cnt;
	logic [2:0] byte_cnt;
	logic [6:0] shift_q;
	logic [7:0] new_byte;
	logic [7:0] cmd_q;
	mist_pkg::config_payload_t payload_q;
	mist_pkg::status_word_t status_q;
	logic frame_ok;
	logic ack_wait;
	logic key_busy;

	// Two flops per pin, plus one more on sck and ss for edge detection.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sck_meta <= 1'b0;
			sck_s <= 1'b0;
			sck_prev <= 1'b0;
			ss_meta <= 1'b1;
			ss_s <= 1'b1;
			ss_prev <= 1'b1;
			di_meta <= 1'b0;
			di_s <= 1'b0;
		end else begin
			sck_meta <= spi_sck;
			sck_s <= sck_meta;
			sck_prev <= sck_s;
			ss_meta <= spi_ss;
			ss_s <= ss_meta;
			ss_prev <= ss_s;
			di_meta <= spi_di;
			di_s <= di_meta;
		end
	end

	assign sck_rise = sck_s & ~sck_prev;
	assign ss_rise = ss_s & ~ss_prev; // End of frame.
	assign new_byte = {shift_q, di_s};

	// Bit and byte counters run only while the slave is selected.
	always_ff @(posedge clk_sys) begin
		if (rst || ss_s) begin
			bit_cnt <= 3'd0;
			byte_cnt <= 3'd0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7 && byte_cnt != 3'd7)
				byte_cnt <= byte_cnt + 3'd1; // Saturates so long frames stay invalid.
		end
	end

	// First byte is the command, the rest shift into the payload.
	always_ff @(posedge clk_sys) begin
		if (!ss_s && sck_rise) begin
			shift_q <= new_byte[6:0];
			if (bit_cnt == 3'd7) begin
				if (byte_cnt == 3'd0)
					cmd_q <= new_byte;
				else
					payload_q <= {payload_q[23:0], new_byte};
			end
		end
	end

	// A frame counts only with exactly five whole bytes.
	assign frame_ok = ss_rise && (byte_cnt == mist_pkg::FRAME_BYTES)
		&& (bit_cnt == 3'd0);
	assign key_busy = key_req | ack_wait;

	always_ff @(posedge clk_sys) begin
		if (rst)
			status_q <= '0;
		else if (frame_ok && cmd_q == mist_pkg::CMD_STATUS)
			status_q <= payload_q.status;
	end

	// Four-phase handshake towards the core.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			key_req <= 1'b0;
			ack_wait <= 1'b0;
		end else begin
			if (key_req && key_ack) begin
				key_req <= 1'b0;
				ack_wait <= 1'b1; // Idle only after the core drops ack.
			end else if (ack_wait && !key_ack) begin
				ack_wait <= 1'b0;
			end else if (frame_ok && cmd_q == mist_pkg::CMD_KEY && !key_busy) begin
				key_req <= 1'b1;
			end
		end
	end

	// The code is loaded together with the request and then held.
	always_ff @(posedge clk_sys) begin
		if (frame_ok && cmd_q == mist_pkg::CMD_KEY && !key_busy)
			key_code <= {payload_q.key.reserved, payload_q.key.pressed,
				payload_q.key.extended, payload_q.key.scan_code};
	end

	assign turbo = status_q.turbo;
	assign scanlines_on = |status_q.scanlines;
	assign status_reset = status_q.reset_req;

endmodule

// ==== hw/mist_pkg.sv ====
package mist_pkg;

	// Command bytes sent by the I/O controller.
	localparam logic [7:0] CMD_STATUS = 8'h1E;
	localparam logic [7:0] CMD_KEY = 8'h05;

	// One command byte and four payload bytes per frame, MSB first.
	localparam logic [2:0] FRAME_BYTES = 3'd5;

	// Core reset is held this many cycles after the last cause is gone.
	localparam logic [7:0] RESET_HOLD = 8'd255;

	localparam int COLOUR_BITS = 6;
	localparam int NUM_CHANNELS = 3; // Red, green, blue.

	localparam logic [COLOUR_BITS-1:0] LIT_FULL = 6'd63;
	localparam logic [COLOUR_BITS-1:0] LIT_DIM = 6'd31;

	// Core video to VGA pins, in clk_sys cycles.
	localparam int VIDEO_LATENCY = 3;

	localparam int DAC_BITS = 8;

	// Status view of the payload.
	typedef struct packed {
		logic [26:0] reserved_hi;
		logic [1:0] scanlines; // Any non-zero mode turns dimming on.
		logic turbo;
		logic reserved_lo;
		logic reset_req;
	} status_word_t;

	// Key view of the payload, laid out like a PS/2 key event.
	typedef struct packed {
		logic [20:0] unused;
		logic reserved; // Always sent as zero.
		logic pressed;
		logic extended;
		logic [7:0] scan_code;
	} key_event_t;

	// The command byte picks which view applies.
	typedef union packed {
		status_word_t status;
		key_event_t key;
	} config_payload_t;

endpackage
